//--- speaker_pkg.sv
/*
 * speaker package
 * widths, key codes, timing constants, note set and shared structs
 * for the keyboard melody player
 */
`default_nettype none

package speaker_pkg;

	// *********************************************************
	// widths with a meaning
	// *********************************************************
	typedef logic [8:0]   scan_code_t;
	typedef logic [511:0] key_map_t;
	typedef logic [5:0]   beat_t;
	typedef logic [8:0]   half_period_t;
	typedef logic [11:0]  beat_ticks_t;

	// top bit is the E0 extended flag
	localparam scan_code_t KEY_W     = 9'h01d;
	localparam scan_code_t KEY_S     = 9'h01b;
	localparam scan_code_t KEY_R     = 9'h02d;
	localparam scan_code_t KEY_ENTER = 9'h05a;

	// PS/2 prefix bytes
	localparam logic [7:0] PS2_EXT_BYTE   = 8'he0;
	localparam logic [7:0] PS2_BREAK_BYTE = 8'hf0;

	localparam int PS2_SYNC_STAGES = 2;

	// scaled for simulation
	localparam beat_ticks_t BEAT_TICKS_SLOW = 12'd2048;
	localparam beat_ticks_t BEAT_TICKS_FAST = 12'd1024;
	localparam int          BEAT_COUNT      = 64;

	// *********************************************************
	// notes
	// *********************************************************
	typedef enum logic [3:0] {
		NOTE_REST,
		NOTE_C4, NOTE_D4, NOTE_E4, NOTE_F4, NOTE_G4, NOTE_A4, NOTE_B4,
		NOTE_C5, NOTE_D5, NOTE_E5, NOTE_F5, NOTE_G5
	} note_t;

	// half-period in clock cycles, zero for a rest
	function automatic half_period_t note_half_period(input note_t note);
		case (note)
			NOTE_C4: return 9'd478;
			NOTE_D4: return 9'd426;
			NOTE_E4: return 9'd379;
			NOTE_F4: return 9'd358;
			NOTE_G4: return 9'd319;
			NOTE_A4: return 9'd284;
			NOTE_B4: return 9'd253;
			NOTE_C5: return 9'd239;
			NOTE_D5: return 9'd213;
			NOTE_E5: return 9'd190;
			NOTE_F5: return 9'd179;
			NOTE_G5: return 9'd159;
			default: return 9'd0;
		endcase
	endfunction

	typedef struct packed {
		logic       valid;
		scan_code_t code;
	} key_event_t;

	typedef struct packed {
		logic reverse;
		logic fast;
	} play_mode_t;

endpackage

`default_nettype wire

//--- ps2_key_decoder.sv
/*
 * PS/2 key decoder
 * receives keyboard frames, follows E0/F0 prefixes and keeps
 * a map of the keys held down
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_key_decoder (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     ps2_clk,
	input  wire                     ps2_data,
	output speaker_pkg::key_map_t   key_map,
	output speaker_pkg::key_event_t key_event
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DATA,
		ST_PARITY,
		ST_STOP
	} ps2_state_t;

	logic [speaker_pkg::PS2_SYNC_STAGES-1:0] clk_sync;
	logic [speaker_pkg::PS2_SYNC_STAGES-1:0] data_sync;
	logic ps2_clk_s;
	logic ps2_data_s;
	logic clk_prev;
	logic clk_fall;

	ps2_state_t state;
	logic [2:0] bit_cnt;
	logic [7:0] shreg;
	logic       parity_ok;
	logic       ext_flag;
	logic       brk_flag;
	speaker_pkg::scan_code_t frame_code;

	// *********************************************************
	// line synchronizers and falling edge
	// *********************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			clk_sync  <= '1;
			data_sync <= '1;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[speaker_pkg::PS2_SYNC_STAGES-2:0], ps2_clk};
			data_sync <= {data_sync[speaker_pkg::PS2_SYNC_STAGES-2:0], ps2_data};
			clk_prev  <= ps2_clk_s;
		end
	end

	assign ps2_clk_s  = clk_sync[speaker_pkg::PS2_SYNC_STAGES-1];
	assign ps2_data_s = data_sync[speaker_pkg::PS2_SYNC_STAGES-1];
	assign clk_fall   = clk_prev & ~ps2_clk_s;

	assign frame_code = {ext_flag, shreg};

	// *********************************************************
	// frame FSM and key map
	// *********************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			bit_cnt   <= '0;
			parity_ok <= 1'b0;
			ext_flag  <= 1'b0;
			brk_flag  <= 1'b0;
			key_map   <= '0;
			key_event <= '0;
		end else begin
			key_event.valid <= 1'b0;
			if (clk_fall) begin
				case (state)
					ST_IDLE: begin
						// start bit must be low
						if (!ps2_data_s) begin
							state   <= ST_DATA;
							bit_cnt <= '0;
						end
					end
					ST_DATA: begin
						// lsb first
						shreg   <= {ps2_data_s, shreg[7:1]};
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= ST_PARITY;
					end
					ST_PARITY: begin
						// odd parity over data and parity bit
						parity_ok <= ^{shreg, ps2_data_s};
						state     <= ST_STOP;
					end
					ST_STOP: begin
						state <= ST_IDLE;
						// bad frames vanish here
						if (ps2_data_s && parity_ok) begin
							if (shreg == speaker_pkg::PS2_EXT_BYTE) begin
								ext_flag <= 1'b1;
							end else if (shreg == speaker_pkg::PS2_BREAK_BYTE) begin
								brk_flag <= 1'b1;
							end else begin
								key_map[frame_code] <= ~brk_flag;
								key_event.valid     <= 1'b1;
								key_event.code      <= frame_code;
								ext_flag            <= 1'b0;
								brk_flag            <= 1'b0;
							end
						end
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// one pulse per finished key
	a_event_single: assert property (@(posedge clk) disable iff (!rst_n)
		key_event.valid |=> !key_event.valid);

endmodule

`default_nettype wire

//--- beat_player.sv
/*
 * beat player
 * beat-rate enable and up/down beat counter with restart
 */
`timescale 1ns/1ps
`default_nettype none

module beat_player (
	input  wire                     clk,
	input  wire                     rst_n,
	input  speaker_pkg::play_mode_t mode,
	input  wire                     restart,
	output speaker_pkg::beat_t      beat
);

	speaker_pkg::beat_ticks_t tick_cnt;
	speaker_pkg::beat_ticks_t tick_len;
	speaker_pkg::beat_t       beat_next;
	logic                     tick_end;

	assign tick_end = (tick_cnt == tick_len - 12'd1);

	// step one beat, wrap at both ends
	always_comb begin
		if (mode.reverse) begin
			if (beat == '0)
				beat_next = speaker_pkg::beat_t'(speaker_pkg::BEAT_COUNT - 1);
			else
				beat_next = beat - 6'd1;
		end else begin
			if (beat == speaker_pkg::beat_t'(speaker_pkg::BEAT_COUNT - 1))
				beat_next = '0;
			else
				beat_next = beat + 6'd1;
		end
	end

	// length of the next beat is latched at each boundary
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat     <= '0;
			tick_cnt <= '0;
			tick_len <= speaker_pkg::BEAT_TICKS_SLOW;
		end else if (restart) begin
			beat     <= '0;
			tick_cnt <= '0;
			tick_len <= mode.fast ? speaker_pkg::BEAT_TICKS_FAST : speaker_pkg::BEAT_TICKS_SLOW;
		end else if (tick_end) begin
			beat     <= beat_next;
			tick_cnt <= '0;
			tick_len <= mode.fast ? speaker_pkg::BEAT_TICKS_FAST : speaker_pkg::BEAT_TICKS_SLOW;
		end else begin
			tick_cnt <= tick_cnt + 12'd1;
		end
	end

	a_beat_steady: assert property (@(posedge clk) disable iff (!rst_n)
		(!tick_end && !restart) |=> $stable(beat));

endmodule

`default_nettype wire

//--- tone_rom.sv
/*
 * tone ROM
 * 64-beat melody, each beat mapped to a note half-period
 */
`timescale 1ns/1ps
`default_nettype none

module tone_rom (
	input  speaker_pkg::beat_t        beat,
	output speaker_pkg::half_period_t half_period
);

	speaker_pkg::note_t note;

	// four phrases of two-beat notes, each ending in a rest
	always_comb begin
		note = speaker_pkg::NOTE_REST;
		case (beat)
			6'd0,  6'd1:  note = speaker_pkg::NOTE_C4;
			6'd2,  6'd3:  note = speaker_pkg::NOTE_E4;
			6'd4,  6'd5:  note = speaker_pkg::NOTE_G4;
			6'd6,  6'd7:  note = speaker_pkg::NOTE_C5;
			6'd8,  6'd9:  note = speaker_pkg::NOTE_G4;
			6'd10, 6'd11: note = speaker_pkg::NOTE_E4;
			6'd12, 6'd13: note = speaker_pkg::NOTE_C4;
			6'd14, 6'd15: note = speaker_pkg::NOTE_REST;
			// second phrase a step up
			6'd16, 6'd17: note = speaker_pkg::NOTE_D4;
			6'd18, 6'd19: note = speaker_pkg::NOTE_F4;
			6'd20, 6'd21: note = speaker_pkg::NOTE_A4;
			6'd22, 6'd23: note = speaker_pkg::NOTE_D5;
			6'd24, 6'd25: note = speaker_pkg::NOTE_A4;
			6'd26, 6'd27: note = speaker_pkg::NOTE_F4;
			6'd28, 6'd29: note = speaker_pkg::NOTE_D4;
			6'd30, 6'd31: note = speaker_pkg::NOTE_REST;
			6'd32, 6'd33: note = speaker_pkg::NOTE_E4;
			6'd34, 6'd35: note = speaker_pkg::NOTE_G4;
			6'd36, 6'd37: note = speaker_pkg::NOTE_B4;
			6'd38, 6'd39: note = speaker_pkg::NOTE_E5;
			6'd40, 6'd41: note = speaker_pkg::NOTE_B4;
			6'd42, 6'd43: note = speaker_pkg::NOTE_G4;
			6'd44, 6'd45: note = speaker_pkg::NOTE_E4;
			6'd46, 6'd47: note = speaker_pkg::NOTE_REST;
			// closing run to the top
			6'd48, 6'd49: note = speaker_pkg::NOTE_F4;
			6'd50, 6'd51: note = speaker_pkg::NOTE_A4;
			6'd52, 6'd53: note = speaker_pkg::NOTE_C5;
			6'd54, 6'd55: note = speaker_pkg::NOTE_F5;
			6'd56, 6'd57: note = speaker_pkg::NOTE_G5;
			6'd58, 6'd59: note = speaker_pkg::NOTE_E5;
			6'd60, 6'd61: note = speaker_pkg::NOTE_C5;
			6'd62, 6'd63: note = speaker_pkg::NOTE_REST;
			default:      note = speaker_pkg::NOTE_REST;
		endcase
	end

	assign half_period = speaker_pkg::note_half_period(note);

endmodule

`default_nettype wire

//--- square_gen.sv
/*
 * square-wave tone generator
 * 50 % square wave from a half-period, silent for rests
 */
`timescale 1ns/1ps
`default_nettype none

module square_gen (
	input  wire                       clk,
	input  wire                       rst_n,
	input  speaker_pkg::half_period_t half_period,
	output logic                      audio
);

	speaker_pkg::half_period_t cnt;
	speaker_pkg::half_period_t hp_q;
	logic                      hp_changed;

	assign hp_changed = (half_period != hp_q);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt   <= '0;
			hp_q  <= '0;
			audio <= 1'b0;
		end else begin
			hp_q <= half_period;
			if (half_period == '0) begin
				// rest
				cnt   <= '0;
				audio <= 1'b0;
			end else if (hp_changed || cnt == '0) begin
				cnt <= half_period - 9'd1;
				if (!hp_changed)
					audio <= ~audio;
			end else begin
				cnt <= cnt - 9'd1;
			end
		end
	end

	a_rest_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		(half_period == '0 && $past(half_period) == '0) |-> !audio);

endmodule

`default_nettype wire

//--- speaker_top.sv
/*
 * speaker top
 * keyboard-controlled melody player: PS/2 decoder, play-mode
 * register, beat player, tone ROM and square-wave output
 */
`timescale 1ns/1ps
`default_nettype none

module speaker_top (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     ps2_clk,
	input  wire                     ps2_data,
	output wire                     audio,
	output speaker_pkg::beat_t      beat,
	output speaker_pkg::play_mode_t mode
);

	speaker_pkg::key_map_t     key_map;
	speaker_pkg::key_event_t   key_event;
	speaker_pkg::half_period_t half_period;
	logic                      restart;

	ps2_key_decoder u_keys (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.key_map  (key_map),
		.key_event(key_event)
	);

	// *********************************************************
	// play mode from held keys, W > S > R > Enter
	// *********************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mode    <= '0;
			restart <= 1'b0;
		end else begin
			restart <= 1'b0;
			if (key_event.valid) begin
				if (key_map[speaker_pkg::KEY_W]) begin
					mode.reverse <= 1'b0;
				end else if (key_map[speaker_pkg::KEY_S]) begin
					mode.reverse <= 1'b1;
				end else if (key_map[speaker_pkg::KEY_R]) begin
					mode.fast <= ~mode.fast;
				end else if (key_map[speaker_pkg::KEY_ENTER]) begin
					mode    <= '0;
					restart <= 1'b1;
				end
			end
		end
	end

	beat_player u_player (
		.clk    (clk),
		.rst_n  (rst_n),
		.mode   (mode),
		.restart(restart),
		.beat   (beat)
	);

	tone_rom u_rom (
		.beat       (beat),
		.half_period(half_period)
	);

	square_gen u_tone (
		.clk        (clk),
		.rst_n      (rst_n),
		.half_period(half_period),
		.audio      (audio)
	);

endmodule

`default_nettype wire

//--- speaker_checker.sv
/*
 * speaker checker
 * follows the expected beat and mode, times beats and audio edges
 */
`timescale 1ns/1ps
`default_nettype none

module speaker_checker (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       audio,
	input  speaker_pkg::beat_t        beat,
	input  speaker_pkg::play_mode_t   mode,
	input  speaker_pkg::play_mode_t   exp_mode,
	input  speaker_pkg::half_period_t exp_half,
	input  wire                       restart_note,
	input  wire                       sample_req,
	output speaker_pkg::beat_t        exp_beat,
	output int                        beat_errors,
	output int                        tone_errors,
	output int                        mode_errors
);

	int                 cyc = 0;
	int                 last_change;
	int                 cur_len;
	int                 last_edge;
	int                 edge_cnt;
	logic               audio_prev;
	logic               restart_pending;
	logic               after_reset;
	speaker_pkg::beat_t beat_prev;
	speaker_pkg::beat_t want;

	function automatic int beat_len(input logic fast);
		return fast ? int'(speaker_pkg::BEAT_TICKS_FAST) : int'(speaker_pkg::BEAT_TICKS_SLOW);
	endfunction

	// 6-bit arithmetic wraps modulo 64
	function automatic speaker_pkg::beat_t step_beat(input speaker_pkg::beat_t b, input logic rev);
		return rev ? b - 6'd1 : b + 6'd1;
	endfunction

	// sample on the falling edge away from register updates
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (!rst_n) begin
			exp_beat        = '0;
			beat_prev       = '0;
			audio_prev      = 1'b0;
			last_change     = cyc + 1;
			cur_len         = beat_len(1'b0);
			edge_cnt        = 0;
			restart_pending = 1'b0;
			after_reset     = 1'b1;
			beat_errors     = 0;
			tone_errors     = 0;
			mode_errors     = 0;
		end else begin
			if (after_reset) begin
				after_reset = 1'b0;
				if (audio !== 1'b0 || beat !== '0 || mode !== '0) begin
					$display("[ERROR] %0t reset state: expected audio 0 beat 0 mode 00, got %b %0d %b",
						$time, audio, beat, mode);
					beat_errors++;
				end
			end
			if (restart_note)
				restart_pending = 1'b1;

			// *************************************************
			// beat boundaries
			// *************************************************
			if (beat != beat_prev) begin
				// a note that played the whole beat keeps toggling to its end
				if (!restart_pending && exp_half != '0 &&
						(edge_cnt < 2 || cyc - last_edge > int'(exp_half))) begin
					$display("audio stopped toggling during beat %0d at %0t",
						exp_beat, $time);
					tone_errors++;
				end
				if (restart_pending) begin
					want = '0;
					restart_pending = 1'b0;
				end else begin
					want = step_beat(exp_beat, exp_mode.reverse);
					if (cyc - last_change != cur_len) begin
						$display("[ERROR] %0t beat period: expected %0d, got %0d",
							$time, cur_len, cyc - last_change);
						beat_errors++;
					end
				end
				if (beat != want) begin
					$display("[ERROR] %0t beat: expected %0d, got %0d", $time, want, beat);
					beat_errors++;
				end
				exp_beat    = want;
				last_change = cyc;
				cur_len     = beat_len(exp_mode.fast);
				edge_cnt    = 0;
			end else if (exp_half == '0) begin
				if (audio) begin
					$display("[ERROR] %0t audio: expected 0 during rest, got %b", $time, audio);
					tone_errors++;
				end
			end else if (audio != audio_prev) begin
				// the first edge of a beat only starts the timing
				if (edge_cnt > 0 && cyc - last_edge != int'(exp_half)) begin
					$display("[ERROR] %0t audio half-period: expected %0d, got %0d",
						$time, exp_half, cyc - last_edge);
					tone_errors++;
				end
				edge_cnt++;
				last_edge = cyc;
			end

			if (sample_req) begin
				if (restart_pending) begin
					$display("beat did not return to 0 after Enter at %0t", $time);
					beat_errors++;
				end
				if (mode != exp_mode) begin
					$display("[ERROR] %0t mode: expected %b, got %b", $time, exp_mode, mode);
					mode_errors++;
				end
				if (beat != exp_beat) begin
					$display("[ERROR] %0t beat: expected %0d, got %0d", $time, exp_beat, beat);
					beat_errors++;
				end
			end
			beat_prev  = beat;
			audio_prev = audio;
		end
	end

endmodule

`default_nettype wire

//--- speaker_tb.sv
/*
 * speaker testbench
 * PS/2 keyboard model, key sequences, melody and mode references
 */
`timescale 1ns/1ps
`default_nettype none

module speaker_tb;

	localparam int PS2_HALF     = 20;
	localparam int BEAT_TIMEOUT = 3 * 2048;

	logic                      clk;
	logic                      rst_n;
	logic                      ps2_clk;
	logic                      ps2_data;
	wire                       audio;
	speaker_pkg::beat_t        beat;
	speaker_pkg::play_mode_t   mode;
	speaker_pkg::play_mode_t   exp_mode;
	speaker_pkg::beat_t        exp_beat;
	speaker_pkg::half_period_t exp_half;
	logic                      restart_note;
	logic                      sample_req;
	logic [31:0]               lfsr;
	int                        beat_errors;
	int                        tone_errors;
	int                        mode_errors;
	int                        timeout_errors;
	int                        rnd;

	speaker_top DUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.ps2_clk (ps2_clk),
		.ps2_data(ps2_data),
		.audio   (audio),
		.beat    (beat),
		.mode    (mode)
	);

	speaker_checker u_check (
		.clk         (clk),
		.rst_n       (rst_n),
		.audio       (audio),
		.beat        (beat),
		.mode        (mode),
		.exp_mode    (exp_mode),
		.exp_half    (exp_half),
		.restart_note(restart_note),
		.sample_req  (sample_req),
		.exp_beat    (exp_beat),
		.beat_errors (beat_errors),
		.tone_errors (tone_errors),
		.mode_errors (mode_errors)
	);

	always #2 clk = ~clk;

	// *********************************************************
	// reference models
	// *********************************************************
	// four phrases of two-beat notes, index is beat / 2
	function automatic speaker_pkg::note_t melody_note(input speaker_pkg::beat_t b);
		case (b[5:1])
			5'd0, 5'd6:                  return speaker_pkg::NOTE_C4;
			5'd1, 5'd5, 5'd16, 5'd22:    return speaker_pkg::NOTE_E4;
			5'd2, 5'd4, 5'd17, 5'd21:    return speaker_pkg::NOTE_G4;
			5'd3, 5'd26, 5'd30:          return speaker_pkg::NOTE_C5;
			5'd8, 5'd14:                 return speaker_pkg::NOTE_D4;
			5'd9, 5'd13, 5'd24:          return speaker_pkg::NOTE_F4;
			5'd10, 5'd12, 5'd25:         return speaker_pkg::NOTE_A4;
			5'd11:                       return speaker_pkg::NOTE_D5;
			5'd18, 5'd20:                return speaker_pkg::NOTE_B4;
			5'd19, 5'd29:                return speaker_pkg::NOTE_E5;
			5'd27:                       return speaker_pkg::NOTE_F5;
			5'd28:                       return speaker_pkg::NOTE_G5;
			default:                     return speaker_pkg::NOTE_REST;
		endcase
	endfunction

	assign exp_half = speaker_pkg::note_half_period(melody_note(exp_beat));

	// mode after a key press, one key held at a time
	function automatic speaker_pkg::play_mode_t next_mode(input speaker_pkg::play_mode_t m,
			input speaker_pkg::scan_code_t held);
		speaker_pkg::play_mode_t r;
		r = m;
		if (held == speaker_pkg::KEY_W)
			r.reverse = 1'b0;
		else if (held == speaker_pkg::KEY_S)
			r.reverse = 1'b1;
		else if (held == speaker_pkg::KEY_R)
			r.fast = ~m.fast;
		else if (held == speaker_pkg::KEY_ENTER)
			r = '0;
		return r;
	endfunction

	// galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	// *********************************************************
	// stimulus helpers
	// *********************************************************
	task automatic step_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic wait_beats(input int n);
		speaker_pkg::beat_t start;
		int cnt;
		for (int i = 0; i < n; i++) begin
			start = beat;
			cnt = 0;
			while (beat == start && cnt < BEAT_TIMEOUT) begin
				step_cycles(1);
				cnt++;
			end
			if (beat == start) begin
				$display("timeout: beat stayed at %0d for %0d cycles", start, BEAT_TIMEOUT);
				timeout_errors++;
			end
		end
	endtask

	// start, 8 data bits lsb first, odd parity, stop
	task automatic send_frame(input logic [7:0] data, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			step_cycles(PS2_HALF);
			ps2_clk = 1'b0;
			step_cycles(PS2_HALF);
			ps2_clk = 1'b1;
		end
		step_cycles(2 * PS2_HALF);
	endtask

	task automatic press_key(input speaker_pkg::scan_code_t code, input int min_beats);
		int gap;
		int extra;
		wait_beats(1);
		// a restart from beat 0 would not show as a beat change
		if (code == speaker_pkg::KEY_ENTER && beat == '0)
			wait_beats(1);
		take_bits(5, gap);
		step_cycles(gap + 1);
		exp_mode = next_mode(exp_mode, code);
		if (code == speaker_pkg::KEY_ENTER) begin
			restart_note = 1'b1;
			step_cycles(1);
			restart_note = 1'b0;
		end
		send_frame(code[7:0], 1'b0);
		send_frame(speaker_pkg::PS2_BREAK_BYTE, 1'b0);
		send_frame(code[7:0], 1'b0);
		sample_req = 1'b1;
		step_cycles(1);
		sample_req = 1'b0;
		take_bits(2, extra);
		wait_beats(min_beats + extra);
	endtask

	// *********************************************************
	// test sequence
	// *********************************************************
	initial begin
		clk            = 1'b0;
		rst_n          = 1'b0;
		ps2_clk        = 1'b1;
		ps2_data       = 1'b1;
		restart_note   = 1'b0;
		sample_req     = 1'b0;
		exp_mode       = '0;
		lfsr           = 32'h60c4bc25;
		timeout_errors = 0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		wait_beats(3);
		press_key(speaker_pkg::KEY_R, 3);
		press_key(speaker_pkg::KEY_R, 1);
		press_key(speaker_pkg::KEY_ENTER, 1);
		// reverse from a low beat so the count wraps past 0
		press_key(speaker_pkg::KEY_S, 8);
		press_key(speaker_pkg::KEY_W, 2);

		// corrupted R frame is dropped
		wait_beats(1);
		send_frame(speaker_pkg::KEY_R[7:0], 1'b1);
		sample_req = 1'b1;
		step_cycles(1);
		sample_req = 1'b0;
		wait_beats(2);

		take_bits(7, rnd);
		if (rnd == 'h1d || rnd == 'h1b || rnd == 'h2d || rnd == 'h5a)
			rnd = 'h1c;
		press_key(speaker_pkg::scan_code_t'(rnd), 2);

		$display("errors: beat %0d, tone %0d, mode %0d, timeout %0d",
			beat_errors, tone_errors, mode_errors, timeout_errors);
		if (beat_errors + tone_errors + mode_errors + timeout_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- speaker.f
speaker_pkg.sv
ps2_key_decoder.sv
beat_player.sv
tone_rom.sv
square_gen.sv
speaker_top.sv
speaker_checker.sv
speaker_tb.sv

//--- Makefile
# Verilator build and run for the keyboard melody player

VERILATOR ?= verilator
TOP       ?= speaker_tb
FILELIST  ?= speaker.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TB PASSED

SRCS := $(wildcard *.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
